/* Makefile */
# Verilator build and run of the elevator controller testbench

VERILATOR ?= verilator
TOP       ?= tb_elevator
DUT_TOP   ?= elevator_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "no pass line in log"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+common common/elevator_pkg.sv \
		design/call_register.sv dispatch/request_scan.sv dispatch/travel_ctrl.sv \
		design/door_sequencer.sv design/elevator_top.sv --top-module $(DUT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+common
common/elevator_pkg.sv
design/call_register.sv
dispatch/request_scan.sv
dispatch/travel_ctrl.sv
design/door_sequencer.sv
design/elevator_top.sv
test/tb_elevator.sv

/* common/elevator_config.svh */
// elevator controller sizing and door timing constants
`ifndef ELEVATOR_CONFIG_SVH
`define ELEVATOR_CONFIG_SVH

// building size
`define ELEV_FLOORS     8   // floors served, 0 at the bottom
`define ELEV_FLOOR_W    3   // bits of a floor index

// door timing
`define ELEV_DOOR_DWELL 5   // cycles held open once fully open
`define ELEV_CNT_W      8   // dwell counter width

`endif

/* common/elevator_pkg.sv */
// shared vector types and command encodings of the elevator controller
`include "elevator_config.svh"

package elevator_pkg;

	typedef logic [`ELEV_FLOOR_W-1:0] floor_t;     // floor index
	typedef logic [`ELEV_FLOORS-1:0]  call_mask_t; // one bit per floor

	// engine command, same codes as the motor drive
	typedef enum logic [1:0] {
		ENG_IDLE = 2'd0,
		ENG_DOWN = 2'd1,
		ENG_UP   = 2'd2
	} engine_cmd_t;

	// door actuator command
	typedef enum logic [1:0] {
		DOOR_IDLE  = 2'd0,
		DOOR_OPEN  = 2'd1,
		DOOR_CLOSE = 2'd2
	} door_cmd_t;

	// door position sensor
	typedef enum logic [1:0] {
		POS_BETWEEN = 2'd0,
		POS_OPEN    = 2'd1,
		POS_CLOSED  = 2'd2
	} door_pos_t;

	typedef enum logic {
		DIR_DOWN = 1'b0,
		DIR_UP   = 1'b1
	} dir_t;

endpackage

/* design/call_register.sv */
// call register: latches cabin and hall buttons, drops calls once served
`include "elevator_config.svh"

module call_register (
	input  logic                     clk,
	input  logic                     reset,
	input  elevator_pkg::call_mask_t i_btn_cabin,
	input  elevator_pkg::call_mask_t i_btn_up,
	input  elevator_pkg::call_mask_t i_btn_down,
	input  elevator_pkg::call_mask_t i_clr_cabin,
	input  elevator_pkg::call_mask_t i_clr_up,
	input  elevator_pkg::call_mask_t i_clr_down,
	output elevator_pkg::call_mask_t o_pend_cabin,
	output elevator_pkg::call_mask_t o_pend_up,
	output elevator_pkg::call_mask_t o_pend_down
);
	import elevator_pkg::*;

	// no up button on the top floor, no down button on floor 0
	localparam call_mask_t UP_VALID   = call_mask_t'({1'b0, {(`ELEV_FLOORS-1){1'b1}}});
	localparam call_mask_t DOWN_VALID = call_mask_t'({{(`ELEV_FLOORS-1){1'b1}}, 1'b0});

	call_mask_t press_up;
	call_mask_t press_down;

	assign press_up   = i_btn_up & UP_VALID;
	assign press_down = i_btn_down & DOWN_VALID;

	// a press in the clear cycle survives the clear
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			o_pend_cabin <= '0;
			o_pend_up    <= '0;
			o_pend_down  <= '0;
		end
		else begin
			o_pend_cabin <= (o_pend_cabin & ~i_clr_cabin) | i_btn_cabin;
			o_pend_up    <= (o_pend_up & ~i_clr_up) | press_up;
			o_pend_down  <= (o_pend_down & ~i_clr_down) | press_down;
		end
	end

endmodule

/* design/door_sequencer.sv */
// door sequencer: open, dwell and close cycle with reopen, closed by a req/ack handshake
`include "elevator_config.svh"

module door_sequencer (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    i_door_req,
	input  elevator_pkg::door_pos_t i_sensor_door,
	input  logic                    i_sensor_inside,
	input  logic                    i_overload,
	input  logic                    i_open_btn,
	output logic                    o_door_ack,
	output elevator_pkg::door_cmd_t o_door
);
	import elevator_pkg::*;

	typedef enum logic [2:0] {IDLE, OPENING, DWELL, CLOSING, DONE} state_t;
	typedef logic [`ELEV_CNT_W-1:0] cnt_t;

	localparam cnt_t DWELL_LAST = cnt_t'(`ELEV_DOOR_DWELL - 1);

	state_t state;
	cnt_t   dwell_cnt;
	logic   obstruct;   // anything that keeps the door open

	assign obstruct = i_sensor_inside | i_overload | i_open_btn;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state      <= IDLE;
			dwell_cnt  <= '0;
			o_door     <= DOOR_IDLE;
			o_door_ack <= 1'b0;
		end
		else begin
			case (state)
				IDLE: begin
					if (i_door_req) begin
						o_door <= DOOR_OPEN;
						state  <= OPENING;
					end
				end
				OPENING: begin
					if (i_sensor_door == POS_OPEN) begin
						dwell_cnt <= '0;
						state     <= DWELL;
					end
				end
				DWELL: begin
					if (obstruct)
						dwell_cnt <= '0;    // hold open while blocked
					else if (dwell_cnt == DWELL_LAST) begin
						o_door <= DOOR_CLOSE;
						state  <= CLOSING;
					end
					else
						dwell_cnt <= dwell_cnt + 1'b1;
				end
				CLOSING: begin
					if (obstruct) begin // reopen, dwell starts over
						o_door <= DOOR_OPEN;
						state  <= OPENING;
					end
					else if (i_sensor_door == POS_CLOSED) begin
						o_door     <= DOOR_IDLE;
						o_door_ack <= 1'b1;
						state      <= DONE;
					end
				end
				DONE: begin
					if (!i_door_req) begin  // req dropped, release ack
						o_door_ack <= 1'b0;
						state      <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* design/elevator_top.sv */
// elevator controller top: call register, travel controller and door sequencer
module elevator_top (
	input  logic                      clk,
	input  logic                      reset,
	input  elevator_pkg::call_mask_t  i_btn_cabin,
	input  elevator_pkg::call_mask_t  i_btn_hall_up,
	input  elevator_pkg::call_mask_t  i_btn_hall_down,
	input  logic                      i_sensor_up,
	input  logic                      i_sensor_down,
	input  elevator_pkg::door_pos_t   i_sensor_door,
	input  logic                      i_sensor_inside,
	input  logic                      i_overload,
	input  logic                      i_open_btn,
	output elevator_pkg::engine_cmd_t o_engine,
	output elevator_pkg::door_cmd_t   o_door,
	output elevator_pkg::dir_t        o_direction,
	output elevator_pkg::floor_t      o_level_display
);
	import elevator_pkg::*;

	call_mask_t pend_cabin;
	call_mask_t pend_up;
	call_mask_t pend_down;
	call_mask_t clr_cabin;
	call_mask_t clr_up;
	call_mask_t clr_down;
	logic       door_req;
	logic       door_ack;

	call_register u_calls (
		.clk          (clk),
		.reset        (reset),
		.i_btn_cabin  (i_btn_cabin),
		.i_btn_up     (i_btn_hall_up),
		.i_btn_down   (i_btn_hall_down),
		.i_clr_cabin  (clr_cabin),
		.i_clr_up     (clr_up),
		.i_clr_down   (clr_down),
		.o_pend_cabin (pend_cabin),
		.o_pend_up    (pend_up),
		.o_pend_down  (pend_down)
	);

	travel_ctrl u_travel (
		.clk           (clk),
		.reset         (reset),
		.i_sensor_up   (i_sensor_up),
		.i_sensor_down (i_sensor_down),
		.i_pend_cabin  (pend_cabin),
		.i_pend_up     (pend_up),
		.i_pend_down   (pend_down),
		.i_door_ack    (door_ack),
		.o_door_req    (door_req),
		.o_clr_cabin   (clr_cabin),
		.o_clr_up      (clr_up),
		.o_clr_down    (clr_down),
		.o_engine      (o_engine),
		.o_direction   (o_direction),
		.o_floor       (o_level_display)   // floor register feeds the display
	);

	door_sequencer u_door (
		.clk             (clk),
		.reset           (reset),
		.i_door_req      (door_req),
		.i_sensor_door   (i_sensor_door),
		.i_sensor_inside (i_sensor_inside),
		.i_overload      (i_overload),
		.i_open_btn      (i_open_btn),
		.o_door_ack      (door_ack),
		.o_door          (o_door)
	);

endmodule

/* dispatch/request_scan.sv */
// request scan: pending calls above, below and at a floor for a given direction
module request_scan (
	input  elevator_pkg::call_mask_t i_pend_cabin,
	input  elevator_pkg::call_mask_t i_pend_up,
	input  elevator_pkg::call_mask_t i_pend_down,
	input  elevator_pkg::floor_t     i_floor,
	input  elevator_pkg::dir_t       i_dir,
	output logic                     o_calls_above,
	output logic                     o_calls_below,
	output logic                     o_stop_here_dir,
	output logic                     o_stop_here_rev
);
	import elevator_pkg::*;

	call_mask_t floor_bit;
	call_mask_t below_mask;
	call_mask_t above_mask;
	call_mask_t all_calls;
	call_mask_t hall_dir;
	call_mask_t hall_rev;

	// one-hot of the floor under test
	assign floor_bit  = call_mask_t'(1) << i_floor;
	assign below_mask = floor_bit - 1'b1;              // all floors strictly below
	assign above_mask = ~(below_mask | floor_bit);     // all floors strictly above

	assign all_calls = i_pend_cabin | i_pend_up | i_pend_down;

	assign o_calls_above = |(all_calls & above_mask);
	assign o_calls_below = |(all_calls & below_mask);

	// hall buttons split by travel direction
	always_comb begin
		if (i_dir == DIR_UP) begin
			hall_dir = i_pend_up;
			hall_rev = i_pend_down;
		end
		else begin
			hall_dir = i_pend_down;
			hall_rev = i_pend_up;
		end
	end

	assign o_stop_here_dir = |((i_pend_cabin | hall_dir) & floor_bit);
	assign o_stop_here_rev = |(hall_rev & floor_bit);

endmodule

/* dispatch/travel_ctrl.sv */
// travel controller: drives the cabin, tracks the floor, applies the collective sweep
`include "elevator_config.svh"

module travel_ctrl (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      i_sensor_up,
	input  logic                      i_sensor_down,
	input  elevator_pkg::call_mask_t  i_pend_cabin,
	input  elevator_pkg::call_mask_t  i_pend_up,
	input  elevator_pkg::call_mask_t  i_pend_down,
	input  logic                      i_door_ack,
	output logic                      o_door_req,
	output elevator_pkg::call_mask_t  o_clr_cabin,
	output elevator_pkg::call_mask_t  o_clr_up,
	output elevator_pkg::call_mask_t  o_clr_down,
	output elevator_pkg::engine_cmd_t o_engine,
	output elevator_pkg::dir_t        o_direction,
	output elevator_pkg::floor_t      o_floor
);
	import elevator_pkg::*;

	typedef enum logic [2:0] {START, DOOR, DECIDE, DEPART, MOVE} state_t;

	localparam floor_t TOP_FLOOR = floor_t'(`ELEV_FLOORS - 1);

	state_t     state;
	logic       level;          // cabin level with a floor
	floor_t     next_floor;
	floor_t     scan_floor;
	call_mask_t here_bit;
	logic       calls_above;
	logic       calls_below;
	logic       stop_here_dir;
	logic       stop_here_rev;
	logic       calls_ahead;
	logic       calls_behind;
	logic       at_limit;
	logic       arrive_turn;
	logic       arrive_stop;
	logic       serve_here;
	logic       turn;
	dir_t       flip_dir;
	dir_t       stop_dir;       // direction held after a stop decision
	call_mask_t stop_clr_up;
	call_mask_t stop_clr_down;

	function automatic engine_cmd_t eng_for(dir_t d);
		return (d == DIR_UP) ? ENG_UP : ENG_DOWN;
	endfunction

	assign level      = i_sensor_up & i_sensor_down;
	assign next_floor = (o_direction == DIR_UP) ? o_floor + 1'b1 : o_floor - 1'b1;
	assign scan_floor = (state == MOVE) ? next_floor : o_floor; // next floor while moving
	assign here_bit   = call_mask_t'(1) << scan_floor;

	request_scan u_scan (
		.i_pend_cabin    (i_pend_cabin),
		.i_pend_up       (i_pend_up),
		.i_pend_down     (i_pend_down),
		.i_floor         (scan_floor),
		.i_dir           (o_direction),
		.o_calls_above   (calls_above),
		.o_calls_below   (calls_below),
		.o_stop_here_dir (stop_here_dir),
		.o_stop_here_rev (stop_here_rev)
	);

	assign calls_ahead  = (o_direction == DIR_UP) ? calls_above : calls_below;
	assign calls_behind = (o_direction == DIR_UP) ? calls_below : calls_above;
	assign flip_dir     = dir_t'(~o_direction);

	// end of shaft always stops and turns the cabin around
	assign at_limit    = (o_direction == DIR_UP) ? (next_floor == TOP_FLOOR) : (next_floor == '0);
	assign arrive_turn = at_limit | (stop_here_rev & ~calls_ahead);
	assign arrive_stop = stop_here_dir | arrive_turn;

	// stopped: serve own direction first, turn here only when nothing lies ahead
	assign serve_here = stop_here_dir | (stop_here_rev & ~calls_ahead);

	always_comb begin
		if (state == MOVE)
			turn = arrive_turn;
		else
			turn = (state == DECIDE) & ~stop_here_dir;
	end

	assign stop_dir      = turn ? flip_dir : o_direction;
	assign stop_clr_up   = (stop_dir == DIR_UP) ? here_bit : '0;
	assign stop_clr_down = (stop_dir == DIR_DOWN) ? here_bit : '0;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state       <= START;
			o_door_req  <= 1'b0;
			o_clr_cabin <= '0;
			o_clr_up    <= '0;
			o_clr_down  <= '0;
			o_engine    <= ENG_IDLE;
			o_direction <= DIR_UP;
			o_floor     <= '0;
		end
		else begin
			o_clr_cabin <= '0;  // clears are single-cycle pulses
			o_clr_up    <= '0;
			o_clr_down  <= '0;
			case (state)
				START: begin    // first door cycle at floor 0
					o_door_req  <= 1'b1;
					o_clr_cabin <= here_bit;
					o_clr_up    <= stop_clr_up;
					o_clr_down  <= stop_clr_down;
					state       <= DOOR;
				end
				DOOR: begin
					if (i_door_ack) begin
						o_door_req <= 1'b0;
						state      <= DECIDE;
					end
				end
				DECIDE: begin   // idle here until a call shows up
					if (serve_here) begin
						if (!i_door_ack) begin  // previous handshake fully closed
							o_direction <= stop_dir;
							o_door_req  <= 1'b1;
							o_clr_cabin <= here_bit;
							o_clr_up    <= stop_clr_up;
							o_clr_down  <= stop_clr_down;
							state       <= DOOR;
						end
					end
					else if (calls_ahead) begin
						o_engine <= eng_for(o_direction);
						state    <= DEPART;
					end
					else if (calls_behind) begin
						o_direction <= flip_dir;
						o_engine    <= eng_for(flip_dir);
						state       <= DEPART;
					end
				end
				DEPART: begin
					if (!level)
						state <= MOVE;  // left the floor zone
				end
				MOVE: begin
					if (level) begin
						o_floor <= next_floor;
						if (arrive_stop) begin
							o_engine    <= ENG_IDLE;
							o_direction <= stop_dir;
							o_door_req  <= 1'b1;
							o_clr_cabin <= here_bit;
							o_clr_up    <= stop_clr_up;
							o_clr_down  <= stop_clr_down;
							state       <= DOOR;
						end
						else begin
							state <= DEPART;    // pass without stopping
						end
					end
				end
				default: state <= START;
			endcase
		end
	end

endmodule

/* test/elevator_patterns.txt */
# name cabin_hex up_hex down_hex start_floor obstructions end_dir(1=up) n_stops stops...
# the first line covers the door cycle at floor 0 right after reset
power_up      00 00 00 0 0 1 1 0
cabin_single  08 00 00 0 0 1 1 3
sweep_mixed   22 10 04 3 0 0 4 4 5 2 1
hall_down_top 08 00 40 1 0 0 2 3 6
obstruct      05 00 00 6 2 1 2 2 0
dead_buttons  00 80 01 0 0 1 0
top_floor     80 00 00 0 0 0 1 7
back_to_zero  01 00 00 7 1 1 1 0

/* test/tb_elevator.sv */
// testbench for the elevator controller with shaft and door plant models and stop order checks
module tb_elevator;
	timeunit 1ns;
	timeprecision 100ps;
	import elevator_pkg::*;

	logic        clk;
	logic        reset;
	call_mask_t  i_btn_cabin, i_btn_hall_up, i_btn_hall_down;
	logic        i_sensor_up, i_sensor_down;
	door_pos_t   i_sensor_door;
	logic        i_sensor_inside, i_overload, i_open_btn;
	engine_cmd_t o_engine;
	door_cmd_t   o_door;
	dir_t        o_direction;
	floor_t      o_level_display;

	integer      seed = 81;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_bad = 0;
	string       test_name = "reset";
	floor_t      stops[$];
	int          plant_floor = 0;      // where the shaft model has the cabin
	int          move_step = 0;
	int          cab_timer = 0;
	int          door_timer = 0;
	int          obst_left = 0;
	int          obst_kind = 0;
	logic        obst_check = 1'b0;
	door_cmd_t   prev_door = DOOR_IDLE;

	elevator_top dut (.*);

	always #20 clk = ~clk; // 40 ns period

	task automatic check_floor(string what, floor_t exp, floor_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_engine(string what, engine_cmd_t exp, engine_cmd_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: %s expected %s actual %s", test_name, what,
				exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_door(string what, door_cmd_t exp, door_cmd_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: %s expected %s actual %s", test_name, what,
				exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_dir(string what, dir_t exp, dir_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: %s expected %s actual %s", test_name, what,
				exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic abort_run(string msg);
		$display("%s: %s", test_name, msg);
		$display("TB FAILED");
		$finish;
	endtask

	function automatic int rand_delay();
		return 1 + ($unsigned($random(seed)) % 4);
	endfunction

	// shaft model drops the level sensors on departure and raises them at the next floor
	always @(posedge clk) begin
		#5;
		if (cab_timer > 0)
			cab_timer--;
		else if (i_sensor_up && o_engine != ENG_IDLE) begin
			move_step   = (o_engine == ENG_UP) ? 1 : -1;
			i_sensor_up   = 1'b0;
			i_sensor_down = 1'b0;
			cab_timer   = 2 + ($unsigned($random(seed)) % 6);
		end
		else if (!i_sensor_up) begin
			plant_floor  += move_step;
			i_sensor_up   = 1'b1;
			i_sensor_down = 1'b1;
			cab_timer     = 3;  // hold level long enough to see a stop
		end
	end

	// door model with obstruction injected while closing
	always @(posedge clk) begin
		#5;
		if (obst_check) begin
			check_door("reopen after obstruction", DOOR_OPEN, o_door);
			obst_check      = 1'b0;
			i_sensor_inside = 1'b0;
			i_overload      = 1'b0;
			i_open_btn      = 1'b0;
		end
		else if (o_door == DOOR_CLOSE && i_sensor_door == POS_BETWEEN && obst_left > 0) begin
			case (obst_kind % 3)    // overload, person in the door, open button in turn
				0: i_overload = 1'b1;
				1: i_sensor_inside = 1'b1;
				default: i_open_btn = 1'b1;
			endcase
			obst_kind++;
			obst_left--;
			obst_check = 1'b1;
		end
		if (o_door == DOOR_OPEN && i_sensor_door != POS_OPEN) begin
			if (i_sensor_door != POS_BETWEEN) begin
				i_sensor_door = POS_BETWEEN;
				door_timer    = rand_delay();
			end
			else if (door_timer == 0)
				i_sensor_door = POS_OPEN;
			else
				door_timer--;
		end
		else if (o_door == DOOR_CLOSE && i_sensor_door != POS_CLOSED) begin
			if (i_sensor_door != POS_BETWEEN) begin
				i_sensor_door = POS_BETWEEN;
				door_timer    = rand_delay();
			end
			else if (door_timer == 0)
				i_sensor_door = POS_CLOSED;
			else
				door_timer--;
		end
	end

	// only a fresh door opening counts as a stop
	always @(posedge clk) begin
		#5;
		if (o_door == DOOR_OPEN && prev_door == DOOR_IDLE) begin
			stops.push_back(o_level_display);
			check_floor("display against shaft", floor_t'(plant_floor), o_level_display);
			check_engine("engine at stop", ENG_IDLE, o_engine);
		end
		prev_door = o_door;
	end

	task automatic wait_idle();
		int quiet;
		int n;
		quiet = 0;
		n = 0;
		while (quiet < 20) begin
			@(posedge clk);
			#5;
			if (o_engine == ENG_IDLE && o_door == DOOR_IDLE && i_sensor_door == POS_CLOSED
					&& i_sensor_up)
				quiet++;
			else
				quiet = 0;
			n++;
			if (n > 5000)
				abort_run("the cabin never came to rest with the door closed");
		end
	endtask

	initial begin
		int     fd;
		int     rc;
		string  word;
		string  rest;
		int     cab, up, dn, start, obst, dir_end, n_stops, s;
		floor_t exp_stops[$];
		int     err_before;
		clk = 1'b0;
		reset = 1'b0;
		i_btn_cabin = '0;
		i_btn_hall_up = '0;
		i_btn_hall_down = '0;
		i_sensor_up = 1'b1;     // parked level at floor 0
		i_sensor_down = 1'b1;
		i_sensor_door = POS_CLOSED;
		i_sensor_inside = 1'b0;
		i_overload = 1'b0;
		i_open_btn = 1'b0;
		repeat (15) @(posedge clk);
		#5;
		check_engine("engine in reset", ENG_IDLE, o_engine);
		check_door("door in reset", DOOR_IDLE, o_door);
		check_floor("display in reset", '0, o_level_display);
		@(posedge clk);
		#5 reset = 1'b1;
		fd = $fopen("test/elevator_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file");
			errors++;
		end
		while (fd != 0 && !$feof(fd)) begin
			rc = $fscanf(fd, "%s", word);
			if (rc != 1)
				continue;
			if (word.substr(0, 0) == "#") begin
				rc = $fgets(rest, fd);   // skip comment line
				continue;
			end
			rc = $fscanf(fd, "%h %h %h %d %d %d %d", cab, up, dn, start, obst, dir_end, n_stops);
			exp_stops.delete();
			for (int i = 0; i < n_stops; i++) begin
				rc = $fscanf(fd, "%d", s);
				exp_stops.push_back(floor_t'(s));
			end
			test_name = word;
			err_before = errors;
			wait_idle();
			check_floor("start floor", floor_t'(start), o_level_display);
			if (tests_run > 0)
				stops.delete();  // first test keeps the power-up stop
			obst_left = obst;
			i_btn_cabin = call_mask_t'(cab);
			i_btn_hall_up = call_mask_t'(up);
			i_btn_hall_down = call_mask_t'(dn);
			@(posedge clk);
			#5;
			i_btn_cabin = '0;
			i_btn_hall_up = '0;
			i_btn_hall_down = '0;
			repeat (3) @(posedge clk);
			wait_idle();
			if (stops.size() != exp_stops.size()) begin
				$display("%s: %0d stops seen where %0d were due", test_name, stops.size(),
					exp_stops.size());
				errors++;
			end
			else begin
				foreach (exp_stops[i])
					check_floor($sformatf("stop %0d", i), exp_stops[i], stops[i]);
			end
			if (obst_left != 0) begin
				$display("%s: obstructions left unused, no closing door was seen", test_name);
				errors++;
			end
			check_dir("final direction", dir_t'(dir_end), o_direction);
			tests_run++;
			if (errors != err_before)
				tests_bad++;
			$display("test %s: %s", test_name, (errors == err_before) ? "ok" : "bad");
		end
		if (fd != 0)
			$fclose(fd);
		$display("tests run %0d, tests bad %0d, errors %0d", tests_run, tests_bad, errors);
		if (errors == 0 && tests_run > 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
